/* verilog/execPkg.sv */
package execPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding sources
  ////////////////////////////////////////////////////////////////////////////

  // Register-read value or one of the late results
  typedef enum logic [1:0] {
    fwdReg  = 2'd0,
    fwdDmW  = 2'd1,
    fwdAluW = 2'd2,
    fwdAluM = 2'd3
  } fwdSel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU operations
  // Only aluAdd and aluSub trap on signed overflow
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluAddu = 4'd1,
    aluSub  = 4'd2,
    aluSubu = 4'd3,
    aluAnd  = 4'd4,
    aluOr   = 4'd5,
    aluXor  = 4'd6,
    aluNor  = 4'd7,
    aluSlt  = 4'd8,
    aluSltu = 4'd9,
    aluSll  = 4'd10,
    aluSrl  = 4'd11,
    aluSra  = 4'd12,
    aluLui  = 4'd13
  } aluOp_e;

  // ALU B operand source
  typedef enum logic [1:0] {
    srcReg  = 2'd0,
    srcImm  = 2'd1,
    srcZero = 2'd2
  } aluSrc_e;

  // Stage result source
  typedef enum logic [1:0] {
    outAlu = 2'd0,
    outHi  = 2'd1,
    outLo  = 2'd2
  } exOutSel_e;

  // Multiply/divide unit operations
  typedef enum logic [2:0] {
    mdMult  = 3'd0,
    mdMultu = 3'd1,
    mdDiv   = 3'd2,
    mdDivu  = 3'd3,
    mdMthi  = 3'd4,
    mdMtlo  = 3'd5
  } mdOp_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // Late results for forwarding
  typedef struct packed {
    logic [31:0] dmRdW;
    logic [31:0] aluOW;
    logic [31:0] aluOM;
  } fwdBus_t;

  // Decoded controls for one instruction
  typedef struct packed {
    fwdSel_e   fwdA;
    fwdSel_e   fwdB;
    aluSrc_e   aluSrc;
    aluOp_e    aluOp;
    // Shift amount from operand A instead of shamt field
    logic      shiftVar;
    exOutSel_e exOutSel;
    mdOp_e     mdOp;
  } exCtrl_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  logic [4:0]      shamt,
  input  execPkg::aluOp_e op,
  output logic [31:0]     result,
  output logic            overflow
);

  ////////////////////////////////////////////////////////////////////////////
  // Shared arithmetic
  ////////////////////////////////////////////////////////////////////////////

  logic [31:0] sum;
  logic [31:0] diff;
  logic        sumOvf;
  logic        diffOvf;
  logic        sltRes;
  logic        sltuRes;

  // One adder and one subtractor for the trapping and non-trapping forms
  assign sum  = a + b;
  assign diff = a - b;

  // Same-sign operands but result sign flipped
  assign sumOvf = (a[31] == b[31]) && (sum[31] != a[31]);

  // Operands of opposite sign and result sign differs from a
  assign diffOvf = (a[31] != b[31]) && (diff[31] != a[31]);

  // Signed and unsigned compares
  assign sltRes  = $signed(a) < $signed(b);
  assign sltuRes = a < b;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      execPkg::aluAdd,
      execPkg::aluAddu: begin
        result = sum;
      end
      execPkg::aluSub,
      execPkg::aluSubu: begin
        result = diff;
      end
      // Bitwise group
      execPkg::aluAnd: begin
        result = a & b;
      end
      execPkg::aluOr: begin
        result = a | b;
      end
      execPkg::aluXor: begin
        result = a ^ b;
      end
      execPkg::aluNor: begin
        result = ~(a | b);
      end
      // Compares give 0 or 1
      execPkg::aluSlt: begin
        result = {31'd0, sltRes};
      end
      execPkg::aluSltu: begin
        result = {31'd0, sltuRes};
      end
      // Shifts act on b
      execPkg::aluSll: begin
        result = b << shamt;
      end
      execPkg::aluSrl: begin
        result = b >> shamt;
      end
      execPkg::aluSra: begin
        result = $signed(b) >>> shamt;
      end
      // Immediate into upper half
      execPkg::aluLui: begin
        result = {b[15:0], 16'd0};
      end
      default: begin
        result = sum;
      end
    endcase
  end

  // Trap flag only for add and sub
  // Result still goes out unchanged
  always_comb begin
    case (op)
      execPkg::aluAdd: overflow = sumOvf;
      execPkg::aluSub: overflow = diffOvf;
      default:         overflow = 1'b0;
    endcase
  end

endmodule

/* verilog/mulDiv.sv */
`timescale 1ns/1ps

module mulDiv #(
  parameter int multCycles = 5,
  parameter int divCycles  = 10
) (
  input  logic           clk,
  input  logic           arstN,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  execPkg::mdOp_e op,
  input  logic           start,
  output logic           busy,
  output logic [31:0]    hi,
  output logic [31:0]    lo
);

  // Counter wide enough for the longer latency
  localparam int maxCycles = (multCycles > divCycles) ? multCycles : divCycles;
  localparam int cntW      = $clog2(maxCycles + 1);

  logic [cntW-1:0] cnt;
  logic [cntW-1:0] startCnt;
  logic            accept;
  logic            lastCycle;

  // Operands held for the whole operation
  logic [31:0]     aQ;
  logic [31:0]     bQ;
  execPkg::mdOp_e  opQ;

  logic [63:0]     prodS;
  logic [63:0]     prodU;
  logic            divZero;
  logic [31:0]     divisor;
  logic [31:0]     quotS;
  logic [31:0]     remS;
  logic [31:0]     quotU;
  logic [31:0]     remU;
  logic [31:0]     hiNext;
  logic [31:0]     loNext;

  ////////////////////////////////////////////////////////////////////////////
  // Launch and latency counter
  ////////////////////////////////////////////////////////////////////////////

  // Start while busy is dropped
  // Hazard unit stalls instead
  assign accept    = start && !busy;
  assign busy      = (cnt != '0);
  assign lastCycle = (cnt == cntW'(1));

  // Latency per operation
  // Moves to HI/LO take no cycles
  always_comb begin
    case (op)
      execPkg::mdMult,
      execPkg::mdMultu: startCnt = cntW'(multCycles);
      execPkg::mdDiv,
      execPkg::mdDivu:  startCnt = cntW'(divCycles);
      default:          startCnt = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt <= '0;
    end else if (accept) begin
      cnt <= startCnt;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Operand capture on launch
  always_ff @(posedge clk) begin
    if (accept) begin
      aQ  <= a;
      bQ  <= b;
      opQ <= op;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic on latched operands
  ////////////////////////////////////////////////////////////////////////////

  // Full 64-bit products
  assign prodS = $signed({{32{aQ[31]}}, aQ}) * $signed({{32{bQ[31]}}, bQ});
  assign prodU = {32'd0, aQ} * {32'd0, bQ};

  // Dummy divisor of one keeps the quotient defined
  assign divZero = (bQ == 32'd0);
  assign divisor = divZero ? 32'd1 : bQ;

  // Truncating division
  // remainder carries the dividend sign as MIPS expects
  assign quotS = $signed(aQ) / $signed(divisor);
  assign remS  = $signed(aQ) % $signed(divisor);
  assign quotU = aQ / divisor;
  assign remU  = aQ % divisor;

  always_comb begin
    hiNext = hi;
    loNext = lo;
    case (opQ)
      execPkg::mdMult: begin
        {hiNext, loNext} = prodS;
      end
      execPkg::mdMultu: begin
        {hiNext, loNext} = prodU;
      end
      execPkg::mdDiv: begin
        if (!divZero) begin
          hiNext = remS;
          loNext = quotS;
        end
      end
      execPkg::mdDivu: begin
        if (!divZero) begin
          hiNext = remU;
          loNext = quotU;
        end
      end
      default: begin
        hiNext = hi;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // HI and LO
  ////////////////////////////////////////////////////////////////////////////

  // Direct moves at the start edge
  // results land on the edge where busy falls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hi <= '0;
      lo <= '0;
    end else if (accept && (op == execPkg::mdMthi)) begin
      hi <= a;
    end else if (accept && (op == execPkg::mdMtlo)) begin
      lo <= a;
    end else if (lastCycle) begin
      hi <= hiNext;
      lo <= loNext;
    end
  end

endmodule

/* verilog/execStage.sv */
`timescale 1ns/1ps

module execStage #(
  parameter int multCycles = 5,
  parameter int divCycles  = 10
) (
  input  logic             clk,
  input  logic             arstN,

  // Register-read operands and pass-through fields
  input  logic [31:0]      v1,
  input  logic [31:0]      v2,
  input  logic [31:0]      ext,
  input  logic [31:0]      pc4,
  input  logic [31:0]      pc8,
  input  logic [4:0]       a3,

  // Late results and decoded controls
  input  execPkg::fwdBus_t fwd,
  input  execPkg::exCtrl_t ctrl,

  // Mult/div launch
  input  logic             start,
  input  logic             mdEnable,

  output logic [31:0]      exOut,
  output logic [31:0]      v2Out,
  output logic [31:0]      pc4Out,
  output logic [31:0]      pc8Out,
  output logic [4:0]       a3Out,
  output logic             busy,
  output logic             overflow
);

  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluB;
  logic [4:0]  shamt;
  logic [31:0] aluRes;
  logic [31:0] hi;
  logic [31:0] lo;
  logic        mdStart;

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Four-way pick between register value and late results
  function automatic logic [31:0] fwdPick(
    input execPkg::fwdSel_e sel,
    input logic [31:0]      regVal,
    input execPkg::fwdBus_t late
  );
    logic [31:0] val;
    case (sel)
      execPkg::fwdDmW:  val = late.dmRdW;
      execPkg::fwdAluW: val = late.aluOW;
      execPkg::fwdAluM: val = late.aluOM;
      default:          val = regVal;
    endcase
    return val;
  endfunction

  assign opA = fwdPick(ctrl.fwdA, v1, fwd);
  assign opB = fwdPick(ctrl.fwdB, v2, fwd);

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  // B from rs2, immediate or zero
  always_comb begin
    case (ctrl.aluSrc)
      execPkg::srcReg: aluB = opB;
      execPkg::srcImm: aluB = ext;
      default:         aluB = 32'd0;
    endcase
  end

  // Variable shifts use rs low bits, else shamt field of the instruction
  assign shamt = ctrl.shiftVar ? opA[4:0] : ext[10:6];

  alu aluInst (
    .a        (opA),
    .b        (aluB),
    .shamt    (shamt),
    .op       (ctrl.aluOp),
    .result   (aluRes),
    .overflow (overflow)
  );

  // Flush blocks both launches and HI/LO moves
  assign mdStart = start & mdEnable;

  mulDiv #(
    .multCycles (multCycles),
    .divCycles  (divCycles)
  ) mulDivInst (
    .clk   (clk),
    .arstN (arstN),
    .a     (opA),
    .b     (opB),
    .op    (ctrl.mdOp),
    .start (mdStart),
    .busy  (busy),
    .hi    (hi),
    .lo    (lo)
  );

  // Stage result
  always_comb begin
    case (ctrl.exOutSel)
      execPkg::outHi: exOut = hi;
      execPkg::outLo: exOut = lo;
      default:        exOut = aluRes;
    endcase
  end

  // Forwarded rs2 goes on for stores
  assign v2Out  = opB;
  assign pc4Out = pc4;
  assign pc8Out = pc8;
  assign a3Out  = a3;

endmodule

/* test/execStageTb.sv */
`timescale 1ns/1ps

module execStageTb;

  localparam int multCycles = 5;
  localparam int divCycles  = 10;
  localparam int numTests   = 6;
  // Reset cycles plus a budget per directed test
  localparam int cycleLimit = 16 + numTests * 200;

  logic             clk;
  logic             arstN;
  logic [31:0]      v1;
  logic [31:0]      v2;
  logic [31:0]      ext;
  logic [31:0]      pc4;
  logic [31:0]      pc8;
  logic [4:0]       a3;
  execPkg::fwdBus_t fwd;
  execPkg::exCtrl_t ctrl;
  logic             start;
  logic             mdEnable;
  logic [31:0]      exOut;
  logic [31:0]      v2Out;
  logic [31:0]      pc4Out;
  logic [31:0]      pc8Out;
  logic [4:0]       a3Out;
  logic             busy;
  logic             overflow;

  int seed       = 65;
  int errCount   = 0;
  int testErr    = 0;
  int checkCount = 0;
  int cycleCount = 0;

  // HI and LO as the latest readout expected them
  logic [31:0] hiRef = '0;
  logic [31:0] loRef = '0;

  execStage #(
    .multCycles (multCycles),
    .divCycles  (divCycles)
  ) uut (
    .clk      (clk),
    .arstN    (arstN),
    .v1       (v1),
    .v2       (v2),
    .ext      (ext),
    .pc4      (pc4),
    .pc8      (pc8),
    .a3       (a3),
    .fwd      (fwd),
    .ctrl     (ctrl),
    .start    (start),
    .mdEnable (mdEnable),
    .exOut    (exOut),
    .v2Out    (v2Out),
    .pc4Out   (pc4Out),
    .pc8Out   (pc8Out),
    .a3Out    (a3Out),
    .busy     (busy),
    .overflow (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Simulation timed out after %0d cycles", cycleCount);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      testErr++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic noteError(input string msg);
    errCount++;
    testErr++;
    $display("ERROR: %s", msg);
  endtask

  task automatic endTest(input string name);
    if (testErr == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, testErr);
    end
    testErr = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////////////////////

  // Source picked by a forwarding select
  function automatic logic [31:0] pickSrc(input int sel, input logic [31:0] regVal);
    case (sel)
      1:       return fwd.dmRdW;
      2:       return fwd.aluOW;
      3:       return fwd.aluOM;
      default: return regVal;
    endcase
  endfunction

  function automatic logic [31:0] aluModel(input execPkg::aluOp_e op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [4:0] sh);
    int sa;
    int sb;
    sa = a;
    sb = b;
    case (op)
      execPkg::aluAdd, execPkg::aluAddu: return a + b;
      execPkg::aluSub, execPkg::aluSubu: return a - b;
      execPkg::aluAnd:  return a & b;
      execPkg::aluOr:   return a | b;
      execPkg::aluXor:  return a ^ b;
      execPkg::aluNor:  return ~(a | b);
      execPkg::aluSlt:  return (sa < sb) ? 32'd1 : 32'd0;
      execPkg::aluSltu: return (a < b) ? 32'd1 : 32'd0;
      execPkg::aluSll:  return b << sh;
      execPkg::aluSrl:  return b >> sh;
      execPkg::aluSra:  return sb >>> sh;
      execPkg::aluLui:  return {b[15:0], 16'h0000};
      default:          return 32'd0;
    endcase
  endfunction

  // True result outside the signed 32-bit range
  function automatic logic ovfModel(input execPkg::aluOp_e op, input logic [31:0] a,
                                    input logic [31:0] b);
    int     sa;
    int     sb;
    longint wide;
    sa = a;
    sb = b;
    wide = 0;
    if (op == execPkg::aluAdd) begin
      wide = longint'(sa) + longint'(sb);
    end else if (op == execPkg::aluSub) begin
      wide = longint'(sa) - longint'(sb);
    end
    return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic setIdle();
    ctrl.fwdA     = execPkg::fwdReg;
    ctrl.fwdB     = execPkg::fwdReg;
    ctrl.aluSrc   = execPkg::srcReg;
    ctrl.aluOp    = execPkg::aluAdd;
    ctrl.shiftVar = 1'b0;
    ctrl.exOutSel = execPkg::outAlu;
    ctrl.mdOp     = execPkg::mdMult;
    start         = 1'b0;
    mdEnable      = 1'b1;
  endtask

  // HI then LO through the output mux, one cycle each
  task automatic readHiLo(input string tag, input logic [31:0] expHi, input logic [31:0] expLo);
    @(negedge clk);
    ctrl.exOutSel = execPkg::outHi;
    #1;
    checkVal({"exOut(hi) ", tag}, exOut, expHi);
    @(negedge clk);
    ctrl.exOutSel = execPkg::outLo;
    #1;
    checkVal({"exOut(lo) ", tag}, exOut, expLo);
    ctrl.exOutSel = execPkg::outAlu;
    hiRef = expHi;
    loRef = expLo;
  endtask

  // Launch a mult/div and watch busy for the given latency
  // Optional second start while busy must be dropped
  task automatic runMd(input execPkg::mdOp_e op, input logic [31:0] a, input logic [31:0] b,
                       input int cycles, input logic poke);
    @(negedge clk);
    setIdle();
    v1 = a;
    v2 = b;
    ctrl.mdOp = op;
    start = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      start = 1'b0;
      if (!busy) begin
        noteError($sformatf("busy fell after %0d cycles, expected %0d", i, cycles));
        break;
      end
      if (poke && (i == 1)) begin
        v1 = $random(seed);
        v2 = $random(seed);
        start = 1'b1;
      end
    end
    @(negedge clk);
    start = 1'b0;
    if (busy) begin
      noteError($sformatf("busy still high after %0d cycles", cycles));
    end
  endtask

  // Single-edge move or a start that must not launch
  task automatic moveCheck(input execPkg::mdOp_e op, input logic [31:0] val, input logic en,
                           input logic [31:0] expHi, input logic [31:0] expLo);
    @(negedge clk);
    setIdle();
    v1 = val;
    v2 = ~val;
    ctrl.mdOp = op;
    ctrl.exOutSel = (op == execPkg::mdMtlo) ? execPkg::outLo : execPkg::outHi;
    mdEnable = en;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    checkVal("busy", {31'd0, busy}, 32'd0);
    // Register written by the single start edge
    checkVal("exOut after edge", exOut, (op == execPkg::mdMtlo) ? expLo : expHi);
    readHiLo("after move", expHi, expLo);
    mdEnable = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testForwarding();
    // Reset state first
    checkVal("busy", {31'd0, busy}, 32'd0);
    readHiLo("after reset", 32'd0, 32'd0);
    for (int sel = 0; sel < 4; sel++) begin
      @(negedge clk);
      setIdle();
      v1 = $random(seed);
      v2 = $random(seed);
      fwd.dmRdW = $random(seed);
      fwd.aluOW = $random(seed);
      fwd.aluOM = $random(seed);
      pc4 = $random(seed);
      pc8 = pc4 + 32'd4;
      a3 = 5'($random(seed));
      ctrl.fwdA = execPkg::fwdSel_e'(sel);
      ctrl.fwdB = execPkg::fwdSel_e'(3 - sel);
      #1;
      checkVal("exOut", exOut, pickSrc(sel, v1) + pickSrc(3 - sel, v2));
      checkVal("v2Out", v2Out, pickSrc(3 - sel, v2));
      checkVal("pc4Out", pc4Out, pc4);
      checkVal("pc8Out", pc8Out, pc8);
      checkVal("a3Out", {27'd0, a3Out}, {27'd0, a3});
    end
    endTest("forwarding");
  endtask

  task automatic testAluOps();
    logic [4:0] sh;
    for (int op = 0; op < 14; op++) begin
      for (int sv = 0; sv < 2; sv++) begin
        @(negedge clk);
        setIdle();
        v1 = $random(seed);
        v2 = $random(seed);
        ext = $random(seed);
        ctrl.aluOp = execPkg::aluOp_e'(op);
        ctrl.shiftVar = sv[0];
        #1;
        sh = sv[0] ? v1[4:0] : ext[10:6];
        checkVal($sformatf("exOut op %0d", op), exOut, aluModel(ctrl.aluOp, v1, v2, sh));
        checkVal($sformatf("overflow op %0d", op), {31'd0, overflow},
                 {31'd0, ovfModel(ctrl.aluOp, v1, v2)});
      end
    end
    // Immediate and zero on B
    @(negedge clk);
    ctrl.aluOp = execPkg::aluOr;
    ctrl.aluSrc = execPkg::srcImm;
    #1;
    checkVal("exOut srcImm", exOut, v1 | ext);
    @(negedge clk);
    ctrl.aluSrc = execPkg::srcZero;
    #1;
    checkVal("exOut srcZero", exOut, v1);
    checkVal("v2Out srcZero", v2Out, v2);
    endTest("aluOps");
  endtask

  task automatic testOverflow();
    logic [31:0]     aList [4];
    logic [31:0]     bList [4];
    execPkg::aluOp_e ops [4];
    aList = '{32'h7fffffff, 32'h80000000, 32'h80000000, 32'h7fffffff};
    bList = '{32'h00000001, 32'hffffffff, 32'h00000001, 32'hffffffff};
    ops   = '{execPkg::aluAdd, execPkg::aluAddu, execPkg::aluSub, execPkg::aluSubu};
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 4; k++) begin
        @(negedge clk);
        setIdle();
        v1 = aList[i];
        v2 = bList[i];
        ctrl.aluOp = ops[k];
        #1;
        checkVal("exOut", exOut, aluModel(ops[k], v1, v2, 5'd0));
        checkVal("overflow", {31'd0, overflow}, {31'd0, ovfModel(ops[k], v1, v2)});
      end
    end
    endTest("overflow");
  endtask

  task automatic testMultiply();
    logic [31:0] a;
    logic [31:0] b;
    int          sa;
    int          sb;
    longint      sprod;
    logic [63:0] uprod;
    a = $random(seed);
    b = $random(seed);
    sa = a;
    sb = b;
    sprod = longint'(sa) * longint'(sb);
    uprod = 64'(a) * 64'(b);
    runMd(execPkg::mdMult, a, b, multCycles, 1'b1);
    readHiLo("mult", sprod[63:32], sprod[31:0]);
    runMd(execPkg::mdMultu, a, b, multCycles, 1'b1);
    readHiLo("multu", uprod[63:32], uprod[31:0]);
    endTest("multiply");
  endtask

  task automatic testDivide();
    logic [31:0] a;
    logic [31:0] b;
    int          sa;
    int          sb;
    // Negative dividend, remainder keeps its sign
    // -17 / 5 gives quotient -3 and remainder -2
    sa = -17;
    sb = 5;
    runMd(execPkg::mdDiv, sa, sb, divCycles, 1'b0);
    readHiLo("div fixed", 32'hfffffffe, 32'hfffffffd);
    a = $random(seed);
    b = $random(seed) | 32'd1;
    sa = a;
    sb = b;
    runMd(execPkg::mdDiv, a, b, divCycles, 1'b1);
    readHiLo("div", sa % sb, sa / sb);
    runMd(execPkg::mdDivu, a, b, divCycles, 1'b0);
    readHiLo("divu", a % b, a / b);
    // Zero divisor keeps the divu result
    runMd(execPkg::mdDiv, $random(seed), 32'd0, divCycles, 1'b0);
    readHiLo("div by zero", a % b, a / b);
    endTest("divide");
  endtask

  task automatic testMoves();
    logic [31:0] h;
    logic [31:0] l;
    h = $random(seed);
    l = $random(seed);
    moveCheck(execPkg::mdMthi, h, 1'b1, h, loRef);
    moveCheck(execPkg::mdMtlo, l, 1'b1, h, l);
    // Flushed launches leave HI and LO alone
    moveCheck(execPkg::mdMult, $random(seed), 1'b0, h, l);
    moveCheck(execPkg::mdMthi, $random(seed), 1'b0, h, l);
    moveCheck(execPkg::mdMtlo, $random(seed), 1'b0, h, l);
    endTest("moves");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arstN = 1'b0;
    v1 = '0;
    v2 = '0;
    ext = '0;
    pc4 = '0;
    pc8 = '0;
    a3 = '0;
    fwd = '0;
    setIdle();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    testForwarding();
    testAluOps();
    testOverflow();
    testMultiply();
    testDivide();
    testMoves();

    $display("Tests: %0d, checks: %0d, errors: %0d", numTests, checkCount, errCount);
    if (errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* execStage.f */
verilog/execPkg.sv
verilog/alu.sv
verilog/mulDiv.sv
verilog/execStage.sv
test/execStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module execStageTb -f execStage.f \
  -o execStageSim > build.log 2>&1 \
  && ./obj_dir/execStageSim > sim.log 2>&1 \
  || { echo "Build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
